// File: src.f
design/path_count_pkg.sv
design/tap_byte_deserializer.sv
design/line_parser.sv
design/node_id_mapper.sv
design/path_accumulator.sv
design/tap_result_serializer.sv
design/graph_path_top.sv
verification/graph_path_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; pass only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module graph_path_tb -o graph_path_sim &&
./obj_dir/graph_path_sim | tee /dev/stderr | grep "Test passed" > /dev/null &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/graph_path_tb.sv
`default_nettype none

module graph_path_tb;

    import path_count_pkg::*;

    localparam int MAX_GRAPH_NODES = 40;
    localparam int RESULT_TIMEOUT = 50;
    localparam int RANDOM_GRAPHS = 8;
    localparam logic [31:0] SEED = 32'hbfd3_b1df;

    logic tck;
    logic reset;
    logic tdi;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    int    checks;
    int    errors;
    int    test_errors;
    string start_str;
    string end_str;
    string names [MAX_GRAPH_NODES];
    bit    adj [MAX_GRAPH_NODES][MAX_GRAPH_NODES];

    graph_path_top i_graph_path_top (
        .tck          (tck),
        .reset_i      (reset),
        .tdi_i        (tdi),
        .ir_is_user_i (ir_is_user),
        .capture_dr_i (capture_dr),
        .shift_dr_i   (shift_dr),
        .update_dr_i  (update_dr),
        .tdo_o        (tdo)
    );

    always #50 tck = ~tck;

    function automatic logic [7:0] letter_ascii(input logic [LETTER_BITS-1:0] code);
        return 8'h61 + {3'b000, code};
    endfunction

    // First letter sits in the top slot of the chars view
    function automatic string name_text(input node_name_u name);
        return $sformatf("%c%c%c", letter_ascii(name.chars[2]),
                         letter_ascii(name.chars[1]), letter_ascii(name.chars[0]));
    endfunction

    function automatic string random_name();
        logic [7:0] c0;
        logic [7:0] c1;
        logic [7:0] c2;
        c0 = 8'h61 + 8'($urandom_range(25, 0));
        c1 = 8'h61 + 8'($urandom_range(25, 0));
        c2 = 8'h61 + 8'($urandom_range(25, 0));
        return $sformatf("%c%c%c", c0, c1, c2);
    endfunction

    // Eight shift cycles, LSB first, then one update cycle
    task automatic shift_byte(input logic [7:0] data);
        for (int i = 0; i < 8; i++) begin
            @(negedge tck);
            shift_dr = 1'b1;
            tdi      = data[i];
        end
        @(negedge tck);
        shift_dr  = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    task automatic send_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            shift_byte(text[i]);
        end
        shift_byte(8'h0a);
    endtask

    // Bit 0 is the valid flag, bits 16 to 1 the count
    task automatic read_result(output logic [16:0] value);
        @(negedge tck);
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        for (int i = 0; i < 17; i++) begin
            value[i] = tdo;
            shift_dr = 1'b1;
            @(negedge tck);
        end
        shift_dr = 1'b0;
    endtask

    task automatic wait_result();
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(negedge tck);
            seen = i_graph_path_top.result_stb;
            cycles++;
        end
        if (!seen) begin
            $display("timeout at %0t: no result strobe within %0d cycles", $time, RESULT_TIMEOUT);
            errors++;
            test_errors++;
        end
        repeat (2) @(negedge tck);
    endtask

    task automatic check_value(input string what, input logic [16:0] got,
                               input logic [16:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("mismatch at %0t: %s, read %h expected %h", $time, what, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    // End marker, then read back and compare with a valid result
    task automatic finish_list(input string what, input int expected_count);
        logic [16:0] readback;
        send_line(".");
        wait_result();
        read_result(readback);
        check_value(what, readback, {expected_count[15:0], 1'b1});
    endtask

    task automatic report_test(input string label);
        $display("test %s: %0d errors", label, test_errors);
        test_errors = 0;
    endtask

    task automatic apply_reset();
        @(negedge tck);
        reset = 1'b1;
        repeat (4) @(negedge tck);
        reset = 1'b0;
    endtask

    // Node 0 is the start and always has an edge, so its line comes first
    task automatic random_graph(input int node_count, input int density, input bit with_end);
        int    counts [MAX_GRAPH_NODES];
        int    end_pos;
        bit    fresh;
        bit    any;
        string line;
        names[0] = start_str;
        for (int i = 1; i < node_count; i++) begin
            fresh = 1'b0;
            while (!fresh) begin
                names[i] = random_name();
                fresh = (names[i] != start_str) && (names[i] != end_str);
                for (int k = 0; k < i; k++) begin
                    if (names[k] == names[i]) fresh = 1'b0;
                end
            end
        end
        end_pos = with_end ? int'($urandom_range(node_count - 1, 1)) : -1;
        if (with_end) names[end_pos] = end_str;
        for (int i = 0; i < MAX_GRAPH_NODES; i++) begin
            counts[i] = 0;
            for (int j = 0; j < MAX_GRAPH_NODES; j++) begin
                adj[i][j] = (i < j) && (j < node_count) && ($urandom_range(99, 0) < density);
            end
        end
        adj[0][1] = 1'b1;
        // Streaming count in topological order, wrapping at 16 bits
        counts[0] = 1;
        for (int i = 0; i < node_count; i++) begin
            any  = 1'b0;
            line = {names[i], ":"};
            for (int j = i + 1; j < node_count; j++) begin
                if (adj[i][j]) begin
                    counts[j] = (counts[j] + counts[i]) & 16'hffff;
                    line = {line, " ", names[j]};
                    any = 1'b1;
                end
            end
            if (any) send_line(line);
        end
        finish_list($sformatf("random graph of %0d nodes", node_count),
                    with_end ? counts[end_pos] : 0);
    endtask

    initial begin
        logic [16:0] readback;
        void'($urandom(SEED));
        tck         = 1'b0;
        reset       = 1'b1;
        tdi         = 1'b0;
        ir_is_user  = 1'b1;
        capture_dr  = 1'b0;
        shift_dr    = 1'b0;
        update_dr   = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        start_str   = name_text(START_NAME);
        end_str     = name_text(END_NAME);
        repeat (4) @(negedge tck);
        reset = 1'b0;

        read_result(readback);
        check_value("readback before any list", readback, 17'h0);
        report_test("1 idle readback");

        send_line("you: aaa");
        send_line("aaa: out");
        finish_list("single chain", 1);
        report_test("2 chain");

        // Commas, carriage return, tab and a trailing comment are ignored
        send_line("you: aaa, bbb\r");
        send_line("aaa:  ccc\t");
        send_line("bbb: ccc");
        send_line("ccc: out #1");
        finish_list("diamond", 2);
        report_test("3 diamond");

        send_line("you: aaa bbb");
        send_line("aaa: bbb");
        finish_list("end node missing", 0);
        send_line("you: aaa");
        send_line("bbb: out");
        finish_list("end node unreachable", 0);
        report_test("4 no route");

        for (int g = 0; g < RANDOM_GRAPHS; g++) begin
            random_graph(g < 2 ? MAX_GRAPH_NODES : int'($urandom_range(MAX_GRAPH_NODES, 3)),
                         g < 2 ? 90 : int'($urandom_range(60, 10)), g != 3);
        end
        report_test("5 random graphs");

        send_line("you: aaa bbb");
        shift_byte("a");
        shift_byte("a");
        apply_reset();
        read_result(readback);
        check_value("readback after reset", readback, 17'h0);
        send_line("you: ccc ddd");
        send_line("ccc: out");
        send_line("ddd: eee");
        send_line("eee: out");
        finish_list("list after reset", 2);
        report_test("6 reset mid list");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/graph_path_top.sv
`default_nettype none

module graph_path_top #(
    parameter int MAX_NODES = 64
) (
    input  logic tck,
    input  logic reset_i,
    input  logic tdi_i,
    input  logic ir_is_user_i,
    input  logic capture_dr_i,
    input  logic shift_dr_i,
    input  logic update_dr_i,
    output logic tdo_o
);

    import path_count_pkg::*;

    localparam int IDX_W = $clog2(MAX_NODES);

    // Decode stage
    logic       byte_stb;
    logic [7:0] byte_data;
    logic       src_stb;
    node_name_u src_name;
    logic       edge_stb;
    node_name_u dst_name;
    logic       list_done_stb;

    // Execute stage
    logic             src_idx_stb;
    logic [IDX_W-1:0] src_idx;
    logic             edge_idx_stb;
    logic [IDX_W-1:0] dst_idx;
    logic             done_idx_stb;
    logic [IDX_W-1:0] start_idx;
    logic [IDX_W-1:0] end_idx;
    logic             end_known;

    // Result stage
    logic                    result_stb;
    logic [RESULT_WIDTH-1:0] result_count;

    tap_byte_deserializer i_tap_byte_deserializer (
        .tck          (tck),
        .reset_i      (reset_i),
        .tdi_i        (tdi_i),
        .ir_is_user_i (ir_is_user_i),
        .shift_dr_i   (shift_dr_i),
        .update_dr_i  (update_dr_i),
        .byte_stb_o   (byte_stb),
        .byte_data_o  (byte_data)
    );

    line_parser i_line_parser (
        .tck             (tck),
        .reset_i         (reset_i),
        .byte_stb_i      (byte_stb),
        .byte_data_i     (byte_data),
        .src_stb_o       (src_stb),
        .src_name_o      (src_name),
        .edge_stb_o      (edge_stb),
        .dst_name_o      (dst_name),
        .list_done_stb_o (list_done_stb)
    );

    node_id_mapper #(.MAX_NODES(MAX_NODES)) i_node_id_mapper (
        .tck             (tck),
        .reset_i         (reset_i),
        .src_stb_i       (src_stb),
        .src_name_i      (src_name),
        .edge_stb_i      (edge_stb),
        .dst_name_i      (dst_name),
        .list_done_stb_i (list_done_stb),
        .src_idx_stb_o   (src_idx_stb),
        .src_idx_o       (src_idx),
        .edge_idx_stb_o  (edge_idx_stb),
        .dst_idx_o       (dst_idx),
        .done_idx_stb_o  (done_idx_stb),
        .start_idx_o     (start_idx),
        .end_idx_o       (end_idx),
        .end_known_o     (end_known)
    );

    path_accumulator #(.MAX_NODES(MAX_NODES)) i_path_accumulator (
        .tck            (tck),
        .reset_i        (reset_i),
        .src_idx_stb_i  (src_idx_stb),
        .src_idx_i      (src_idx),
        .edge_idx_stb_i (edge_idx_stb),
        .dst_idx_i      (dst_idx),
        .done_idx_stb_i (done_idx_stb),
        .start_idx_i    (start_idx),
        .end_idx_i      (end_idx),
        .end_known_i    (end_known),
        .result_stb_o   (result_stb),
        .result_count_o (result_count)
    );

    tap_result_serializer i_tap_result_serializer (
        .tck            (tck),
        .reset_i        (reset_i),
        .ir_is_user_i   (ir_is_user_i),
        .capture_dr_i   (capture_dr_i),
        .shift_dr_i     (shift_dr_i),
        .result_stb_i   (result_stb),
        .result_count_i (result_count),
        .tdo_o          (tdo_o)
    );

endmodule

`default_nettype wire

// File: design/tap_result_serializer.sv
`default_nettype none

module tap_result_serializer (
    input  logic                                    tck,
    input  logic                                    reset_i,
    input  logic                                    ir_is_user_i,
    input  logic                                    capture_dr_i,
    input  logic                                    shift_dr_i,
    input  logic                                    result_stb_i,
    input  logic [path_count_pkg::RESULT_WIDTH-1:0] result_count_i,
    output logic                                    tdo_o
);

    import path_count_pkg::*;

    logic [RESULT_WIDTH-1:0] result_q;
    logic                    result_valid_q;
    // Bit 0 is the valid flag, count above it
    logic [RESULT_WIDTH:0]   shift_q;

    assign tdo_o = shift_q[0];

    always_ff @(posedge tck) begin
        if (reset_i) begin
            result_q       <= '0;
            result_valid_q <= 1'b0;
            shift_q        <= '0;
        end else begin
            if (result_stb_i) begin
                result_q       <= result_count_i;
                result_valid_q <= 1'b1;
            end
            if (capture_dr_i && ir_is_user_i) begin
                shift_q <= {result_q, result_valid_q};
            end else if (shift_dr_i && ir_is_user_i) begin
                shift_q <= {1'b0, shift_q[RESULT_WIDTH:1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/path_accumulator.sv
`default_nettype none

module path_accumulator #(
    parameter int MAX_NODES = 64,
    localparam int IDX_W = $clog2(MAX_NODES)
) (
    input  logic                                    tck,
    input  logic                                    reset_i,
    input  logic                                    src_idx_stb_i,
    input  logic [IDX_W-1:0]                        src_idx_i,
    input  logic                                    edge_idx_stb_i,
    input  logic [IDX_W-1:0]                        dst_idx_i,
    input  logic                                    done_idx_stb_i,
    input  logic [IDX_W-1:0]                        start_idx_i,
    input  logic [IDX_W-1:0]                        end_idx_i,
    input  logic                                    end_known_i,
    output logic                                    result_stb_o,
    output logic [path_count_pkg::RESULT_WIDTH-1:0] result_count_o
);

    import path_count_pkg::*;

    logic [RESULT_WIDTH-1:0] count_mem [MAX_NODES];
    // Marks entries written during the current list
    logic [MAX_NODES-1:0]    touched_q;
    logic [RESULT_WIDTH-1:0] src_count_q;
    logic                    src_seen_q;
    logic [RESULT_WIDTH-1:0] src_count_rd;
    logic [RESULT_WIDTH-1:0] dst_count_rd;
    logic [RESULT_WIDTH-1:0] end_count_rd;
    logic                    edge_ok;

    // Untouched entries read as zero
    assign src_count_rd = touched_q[src_idx_i] ? count_mem[src_idx_i] : '0;
    assign dst_count_rd = touched_q[dst_idx_i] ? count_mem[dst_idx_i] : '0;
    assign end_count_rd = touched_q[end_idx_i] ? count_mem[end_idx_i] : '0;
    assign edge_ok      = edge_idx_stb_i && src_seen_q;

    always_ff @(posedge tck) begin
        // Source count is final here since lines come in topological order
        if (src_idx_stb_i) begin
            if (src_idx_i == start_idx_i) begin
                src_count_q <= RESULT_WIDTH'(1);
            end else begin
                src_count_q <= src_count_rd;
            end
        end
        if (edge_ok) begin
            count_mem[dst_idx_i] <= dst_count_rd + src_count_q;
        end
        if (done_idx_stb_i) begin
            result_count_o <= end_known_i ? end_count_rd : '0;
        end
    end

    always_ff @(posedge tck) begin
        if (reset_i) begin
            touched_q    <= '0;
            src_seen_q   <= 1'b0;
            result_stb_o <= 1'b0;
        end else begin
            result_stb_o <= done_idx_stb_i;
            if (done_idx_stb_i) begin
                touched_q  <= '0;
                src_seen_q <= 1'b0;
            end else begin
                if (src_idx_stb_i) begin
                    src_seen_q <= 1'b1;
                end
                if (edge_ok) begin
                    touched_q[dst_idx_i] <= 1'b1;
                end
            end
        end
    end

    // Every edge line starts with a source name
    a_edge_after_src: assert property (
        @(posedge tck) disable iff (reset_i)
        edge_idx_stb_i |-> src_seen_q
    );

endmodule

`default_nettype wire

// File: design/node_id_mapper.sv
`default_nettype none

module node_id_mapper #(
    parameter int MAX_NODES = 64,
    localparam int IDX_W = $clog2(MAX_NODES)
) (
    input  logic                       tck,
    input  logic                       reset_i,
    input  logic                       src_stb_i,
    input  path_count_pkg::node_name_u src_name_i,
    input  logic                       edge_stb_i,
    input  path_count_pkg::node_name_u dst_name_i,
    input  logic                       list_done_stb_i,
    output logic                       src_idx_stb_o,
    output logic [IDX_W-1:0]           src_idx_o,
    output logic                       edge_idx_stb_o,
    output logic [IDX_W-1:0]           dst_idx_o,
    output logic                       done_idx_stb_o,
    output logic [IDX_W-1:0]           start_idx_o,
    output logic [IDX_W-1:0]           end_idx_o,
    output logic                       end_known_o
);

    import path_count_pkg::*;

    logic [MAX_NODES-1:0]  valid_q;
    logic [NAME_WIDTH-1:0] key_q [MAX_NODES];
    logic [IDX_W:0]        next_free_q;
    node_name_u            name_sel;
    logic                  hit;
    logic [IDX_W-1:0]      hit_idx;
    logic [IDX_W-1:0]      idx_sel;
    logic                  full;
    logic                  need_alloc;
    logic                  alloc;

    assign name_sel   = src_stb_i ? src_name_i : dst_name_i;
    assign full       = (next_free_q == (IDX_W + 1)'(MAX_NODES));
    assign need_alloc = (src_stb_i || edge_stb_i) && !hit;
    assign alloc      = need_alloc && !full;
    assign idx_sel    = hit ? hit_idx : next_free_q[IDX_W-1:0];

    // Compare against every entry at once
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < MAX_NODES; i++) begin
            if (valid_q[i] && key_q[i] == name_sel.key) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge tck) begin
        if (alloc) begin
            key_q[idx_sel] <= name_sel.key;
        end
        src_idx_o <= idx_sel;
        dst_idx_o <= idx_sel;
    end

    always_ff @(posedge tck) begin
        if (reset_i) begin
            valid_q        <= '0;
            next_free_q    <= '0;
            src_idx_stb_o  <= 1'b0;
            edge_idx_stb_o <= 1'b0;
            done_idx_stb_o <= 1'b0;
            start_idx_o    <= '0;
            end_idx_o      <= '0;
            end_known_o    <= 1'b0;
        end else begin
            src_idx_stb_o  <= src_stb_i;
            edge_idx_stb_o <= edge_stb_i;
            done_idx_stb_o <= list_done_stb_i;
            // Table is emptied once the accumulator has seen the done strobe
            if (done_idx_stb_o) begin
                valid_q     <= '0;
                next_free_q <= '0;
                end_known_o <= 1'b0;
            end else if (alloc) begin
                valid_q[idx_sel] <= 1'b1;
                next_free_q      <= next_free_q + 1'b1;
                if (name_sel.key == START_NAME.key) begin
                    start_idx_o <= idx_sel;
                end
                if (name_sel.key == END_NAME.key) begin
                    end_idx_o   <= idx_sel;
                    end_known_o <= 1'b1;
                end
            end
        end
    end

    a_no_alloc_when_full: assert property (
        @(posedge tck) disable iff (reset_i)
        need_alloc |-> !full
    );

endmodule

`default_nettype wire

// File: design/line_parser.sv
`default_nettype none

module line_parser (
    input  logic                     tck,
    input  logic                     reset_i,
    input  logic                     byte_stb_i,
    input  logic [7:0]               byte_data_i,
    output logic                     src_stb_o,
    output path_count_pkg::node_name_u src_name_o,
    output logic                     edge_stb_o,
    output path_count_pkg::node_name_u dst_name_o,
    output logic                     list_done_stb_o
);

    import path_count_pkg::*;

    localparam int CNT_W = $clog2(NAME_CHARS + 1);

    localparam logic [7:0] CH_NL    = 8'h0a;
    localparam logic [7:0] CH_SPACE = 8'h20;
    localparam logic [7:0] CH_DOT   = 8'h2e;
    localparam logic [7:0] CH_COLON = 8'h3a;
    localparam logic [7:0] CH_A     = 8'h61;
    localparam logic [7:0] CH_Z     = 8'h7a;

    // Position in the current line
    localparam logic [1:0] ST_SRC    = 2'd0;
    localparam logic [1:0] ST_DST    = 2'd1;
    localparam logic [1:0] ST_IN_DST = 2'd2;
    localparam logic [1:0] ST_END    = 2'd3;

    logic [1:0]             state_q;
    logic [CNT_W-1:0]       cnt_q;
    node_name_u             name_q;
    logic                   is_letter;
    logic                   name_full;
    logic [LETTER_BITS-1:0] letter_code;

    assign is_letter   = (byte_data_i >= CH_A) && (byte_data_i <= CH_Z);
    assign letter_code = LETTER_BITS'(byte_data_i - CH_A);
    assign name_full   = (cnt_q == CNT_W'(NAME_CHARS));

    // Name assembly, letter by letter into the chars view
    always_ff @(posedge tck) begin
        if (byte_stb_i && is_letter) begin
            name_q.chars <= {name_q.chars[NAME_CHARS-2:0], letter_code};
        end
        if (byte_stb_i && byte_data_i == CH_COLON) begin
            src_name_o <= name_q;
        end
        if (byte_stb_i && (byte_data_i == CH_SPACE || byte_data_i == CH_NL)) begin
            dst_name_o <= name_q;
        end
    end

    always_ff @(posedge tck) begin
        if (reset_i) begin
            state_q         <= ST_SRC;
            cnt_q           <= '0;
            src_stb_o       <= 1'b0;
            edge_stb_o      <= 1'b0;
            list_done_stb_o <= 1'b0;
        end else begin
            src_stb_o       <= 1'b0;
            edge_stb_o      <= 1'b0;
            list_done_stb_o <= 1'b0;
            if (byte_stb_i && is_letter && state_q != ST_END) begin
                if (!name_full) begin
                    cnt_q <= cnt_q + 1'b1;
                end
                if (state_q == ST_DST) begin
                    state_q <= ST_IN_DST;
                end
            end else if (byte_stb_i) begin
                case (byte_data_i)
                    CH_COLON: begin
                        cnt_q <= '0;
                        if (state_q == ST_SRC && name_full) begin
                            src_stb_o <= 1'b1;
                            state_q   <= ST_DST;
                        end
                    end
                    CH_SPACE: begin
                        cnt_q <= '0;
                        if (state_q == ST_IN_DST) begin
                            edge_stb_o <= name_full;
                            state_q    <= ST_DST;
                        end
                    end
                    CH_NL: begin
                        cnt_q           <= '0;
                        edge_stb_o      <= (state_q == ST_IN_DST) && name_full;
                        list_done_stb_o <= (state_q == ST_END);
                        state_q         <= ST_SRC;
                    end
                    CH_DOT: begin
                        // End marker only counts at the start of a line
                        if (state_q == ST_SRC && cnt_q == '0) begin
                            state_q <= ST_END;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    a_src_edge_exclusive: assert property (
        @(posedge tck) disable iff (reset_i)
        !(src_stb_o && edge_stb_o)
    );

endmodule

`default_nettype wire

// File: design/tap_byte_deserializer.sv
`default_nettype none

module tap_byte_deserializer (
    input  logic       tck,
    input  logic       reset_i,
    input  logic       tdi_i,
    input  logic       ir_is_user_i,
    input  logic       shift_dr_i,
    input  logic       update_dr_i,
    output logic       byte_stb_o,
    output logic [7:0] byte_data_o
);

    logic [7:0] shift_q;

    // LSB arrives first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (shift_dr_i && ir_is_user_i) begin
            shift_q <= {tdi_i, shift_q[7:1]};
        end
        if (update_dr_i && ir_is_user_i) begin
            byte_data_o <= shift_q;
        end
    end

    always_ff @(posedge tck) begin
        if (reset_i) begin
            byte_stb_o <= 1'b0;
        end else begin
            byte_stb_o <= update_dr_i && ir_is_user_i;
        end
    end

    // TAP is in one DR state at a time
    a_shift_update_exclusive: assert property (
        @(posedge tck) disable iff (reset_i)
        !(shift_dr_i && update_dr_i)
    );

endmodule

`default_nettype wire

// File: design/path_count_pkg.sv
`default_nettype none

package path_count_pkg;

    // Letter codes run from a = 0 to z = 25
    localparam int LETTER_BITS = 5;
    localparam int NAME_CHARS = 3;
    localparam int NAME_WIDTH = NAME_CHARS * LETTER_BITS;

    // Path counts wrap modulo 2^16
    localparam int RESULT_WIDTH = 16;

    // First letter of a name sits in chars[NAME_CHARS-1]
    typedef union packed {
        logic [NAME_CHARS-1:0][LETTER_BITS-1:0] chars;
        logic [NAME_WIDTH-1:0]                  key;
    } node_name_u;

    // "you"
    localparam node_name_u START_NAME = node_name_u'({5'd24, 5'd14, 5'd20});
    // "out"
    localparam node_name_u END_NAME = node_name_u'({5'd14, 5'd20, 5'd19});

endpackage

`default_nettype wire
